/* filelist.f */
+incdir+source
source/riscv_pkg.sv
source/instDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/loadStoreAlign.sv
source/riscvCore.sv
verification/riscvCore_props.sv
verification/riscvCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run, and judge the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module riscvCore_tb \
   --Mdir build \
   -o simv

./build/simv | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* source/aluUnit.sv */
// ALU with adder, shifter, compares, logic ops and branch condition
`timescale 1ns/1ps
`include "riscv_consts.svh"
module aluUnit (
   input  logic [31:0]       a,
   input  logic [31:0]       b,
   input  riscv_pkg::aluOp_t op,
   input  logic [2:0]        funct3,
   output logic [31:0]       result,
   output logic              branchTaken
);
   import riscv_pkg::*;

   logic [4:0] shamt;
   logic       equal;
   logic       lessSigned;
   logic       lessUnsigned;

   assign shamt = b[4:0];
   assign equal = (a == b);
   assign lessSigned = ($signed(a) < $signed(b));
   assign lessUnsigned = (a < b);

   always_comb
   begin
      case (op)
         ALU_SUB:   result = a - b;
         ALU_SLL:   result = a << shamt;
         ALU_SLT:   result = {31'b0, lessSigned};
         ALU_SLTU:  result = {31'b0, lessUnsigned};
         ALU_XOR:   result = a ^ b;
         ALU_SRL:   result = a >> shamt;
         ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         ALU_PASSB: result = b;
         default:   result = a + b;
      endcase
   end

   // Condition only, the core qualifies it with isBranch
   always_comb
   begin
      case (funct3)
         `F3_BEQ:  branchTaken = equal;
         `F3_BNE:  branchTaken = !equal;
         `F3_BLT:  branchTaken = lessSigned;
         `F3_BGE:  branchTaken = !lessSigned;
         `F3_BLTU: branchTaken = lessUnsigned;
         `F3_BGEU: branchTaken = !lessUnsigned;
         default:  branchTaken = 1'b0;
      endcase
   end

endmodule

/* source/instDecoder.sv */
// Instruction decoder with immediate generation and execute/writeback control
`timescale 1ns/1ps
`include "riscv_consts.svh"
module instDecoder (
   input  riscv_pkg::instWord_t inst,
   output logic [4:0]           rs1,
   output logic [4:0]           rs2,
   output logic [4:0]           rd,
   output logic [31:0]          imm,
   output riscv_pkg::aluOp_t    aluOp,
   output logic                 aluSrcImm,
   output logic                 usePc,
   output logic                 regWrite,
   output logic                 isLoad,
   output logic                 isStore,
   output logic                 isBranch,
   output logic                 isJal,
   output logic                 isJalr,
   output logic [2:0]           funct3,
   output riscv_pkg::wbSel_t    wbSel
);
   import riscv_pkg::*;

   logic [6:0] opcode;

   // SUB only exists in register form, SRA in both
   function automatic aluOp_t mapAluOp(input logic [2:0] f3, input logic alt,
                                       input logic regForm);
      aluOp_t op;
      case (f3)
         `F3_ADD:  op = (alt && regForm) ? ALU_SUB : ALU_ADD;
         `F3_SLL:  op = ALU_SLL;
         `F3_SLT:  op = ALU_SLT;
         `F3_SLTU: op = ALU_SLTU;
         `F3_XOR:  op = ALU_XOR;
         `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
         `F3_OR:   op = ALU_OR;
         `F3_AND:  op = ALU_AND;
      endcase
      return op;
   endfunction

   assign opcode = inst.r.opcode;
   assign funct3 = inst.r.funct3;

   // Immediate, sign taken from bit 31 in every format
   always_comb
   begin
      case (opcode)
         `OP_IMM, `OP_LOAD, `OP_JALR:
            imm = {{20{inst.i.imm[11]}}, inst.i.imm};
         `OP_STORE:
            imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
         `OP_BRANCH:
            imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                   inst.b.imm4_1, 1'b0};
         `OP_LUI, `OP_AUIPC:
            imm = {inst.u.imm31_12, 12'b0};
         `OP_JAL:
            imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                   inst.j.imm10_1, 1'b0};
         default:
            imm = 32'b0;
      endcase
   end

   always_comb
   begin
      rs1 = inst.r.rs1;
      rs2 = inst.r.rs2;
      rd = inst.r.rd;
      aluOp = ALU_ADD;
      aluSrcImm = 1'b0;
      usePc = 1'b0;
      regWrite = 1'b0;
      isLoad = 1'b0;
      isStore = 1'b0;
      isBranch = 1'b0;
      isJal = 1'b0;
      isJalr = 1'b0;
      wbSel = WB_ALU;
      // Unused source fields go to x0 so they never trigger a hazard
      case (opcode)
         `OP_LUI:
         begin
            {rs1, rs2} = 10'b0;
            {regWrite, aluSrcImm} = 2'b11;
            aluOp = ALU_PASSB;
         end
         `OP_AUIPC:
         begin
            {rs1, rs2} = 10'b0;
            {regWrite, aluSrcImm, usePc} = 3'b111;
         end
         `OP_JAL:
         begin
            {rs1, rs2} = 10'b0;
            {regWrite, isJal} = 2'b11;
            wbSel = WB_LINK;
         end
         `OP_JALR:
         begin
            rs2 = 5'b0;
            {regWrite, isJalr, aluSrcImm} = 3'b111;
            wbSel = WB_LINK;
         end
         `OP_BRANCH:
         begin
            rd = 5'b0;
            isBranch = 1'b1;
         end
         `OP_LOAD:
         begin
            rs2 = 5'b0;
            {regWrite, isLoad, aluSrcImm} = 3'b111;
            wbSel = WB_LOAD;
         end
         `OP_STORE:
         begin
            rd = 5'b0;
            {isStore, aluSrcImm} = 2'b11;
         end
         `OP_IMM:
         begin
            rs2 = 5'b0;
            {regWrite, aluSrcImm} = 2'b11;
            aluOp = mapAluOp(inst.r.funct3, inst.r.funct7[5], 1'b0);
         end
         `OP_REG:
         begin
            regWrite = 1'b1;
            aluOp = mapAluOp(inst.r.funct3, inst.r.funct7[5], 1'b1);
         end
         default:
         begin
            // Unsupported opcode behaves as a NOP
            {rs1, rs2, rd} = 15'b0;
         end
      endcase
   end

endmodule

/* source/loadStoreAlign.sv */
// Store lane placement with byte enables, and load extraction with extension
`timescale 1ns/1ps
`include "riscv_consts.svh"
module loadStoreAlign (
   input  logic [2:0]  storeF3,
   input  logic [2:0]  loadF3,
   input  logic        storeEn,
   input  logic [1:0]  storeAddrLow,
   input  logic [1:0]  loadAddrLow,
   input  logic [31:0] storeData,
   output logic [3:0]  byteEnables,
   output logic [31:0] shiftedData,
   input  logic [31:0] loadWord,
   output logic [31:0] loadResult
);

   logic [3:0]  laneMask;
   logic [31:0] loadShifted;

   // Store side, execute stage
   always_comb
   begin
      case (storeF3)
         `F3_B:
         begin
            shiftedData = {4{storeData[7:0]}};
            laneMask = 4'b0001 << storeAddrLow;
         end
         `F3_H:
         begin
            shiftedData = {2{storeData[15:0]}};
            laneMask = storeAddrLow[1] ? 4'b1100 : 4'b0011;
         end
         default:
         begin
            shiftedData = storeData;
            laneMask = 4'b1111;
         end
      endcase
   end

   assign byteEnables = storeEn ? laneMask : 4'b0000;

   // Load side, writeback stage
   assign loadShifted = loadWord >> {loadAddrLow, 3'b000};

   always_comb
   begin
      case (loadF3)
         `F3_B:   loadResult = {{24{loadShifted[7]}}, loadShifted[7:0]};
         `F3_H:   loadResult = {{16{loadShifted[15]}}, loadShifted[15:0]};
         `F3_BU:  loadResult = {24'b0, loadShifted[7:0]};
         `F3_HU:  loadResult = {16'b0, loadShifted[15:0]};
         default: loadResult = loadWord;
      endcase
   end

endmodule

/* source/regFile.sv */
// 32 x 32-bit register file, two async reads, one sync write, x0 reads zero
`timescale 1ns/1ps
module regFile (
   input  logic        clk,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && (wa != 5'd0))
         regs[wa] <= wd;
   end

   // Write-through so a read in the write cycle sees the new value
   assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we && (wa == ra1)) ? wd : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

/* source/riscvCore.sv */
// Three-stage RV32I core with PC, pipeline registers, forwarding, hazards and writeback
`timescale 1ns/1ps
`include "riscv_consts.svh"
module riscvCore (
   input  logic        clk,
   input  logic        rst,
   input  logic        stall,
   output logic [31:0] icacheAddr,
   output logic        icacheRe,
   input  logic [31:0] instruction,
   output logic [31:0] dcacheAddr,
   output logic [31:0] dcacheDin,
   output logic [3:0]  dcacheWe,
   output logic        dcacheRe,
   input  logic [31:0] dcacheDout
);
   import riscv_pkg::*;

   // Fetch
   logic [`PC_BITS-1:0] pc;

   // Execute
   logic [`PC_BITS-1:0] xPc;
   logic                xNoop;
   instWord_t           xInst;
   logic [4:0]          xRs1, xRs2, xRd;
   logic [31:0]         xImm;
   aluOp_t              xAluOp;
   logic                xAluSrcImm, xUsePc, xRegWrite;
   logic                xIsLoad, xIsStore, xIsBranch, xIsJal, xIsJalr;
   logic [2:0]          xF3;
   wbSel_t              xWbSel;
   logic [31:0]         rd1, rd2, opA, opB, xRs2Val, aluResult;
   logic [31:0]         xPcWord, xLink, branchTarget;
   logic [`PC_BITS-1:0] targetPc;
   logic                branchTaken, loadUse, redirect, fwdA, fwdB, storeEn;

   // Writeback
   logic        wRegWrite;
   wbSel_t      wWbSel;
   logic [4:0]  wRd;
   logic [2:0]  wF3;
   logic [31:0] wAluOut, wLink, wFwdVal, loadResult, rdVal;

   // Squashed slot enters execute as a NOP
   assign xInst = xNoop ? `NOP_WORD : instruction;

   instDecoder decoder_i (
      .inst(xInst), .rs1(xRs1), .rs2(xRs2), .rd(xRd), .imm(xImm), .aluOp(xAluOp),
      .aluSrcImm(xAluSrcImm), .usePc(xUsePc), .regWrite(xRegWrite), .isLoad(xIsLoad),
      .isStore(xIsStore), .isBranch(xIsBranch), .isJal(xIsJal), .isJalr(xIsJalr),
      .funct3(xF3), .wbSel(xWbSel)
   );

   regFile regs_i (
      .clk(clk), .we(wRegWrite & ~stall), .ra1(xRs1), .ra2(xRs2), .wa(wRd),
      .wd(rdVal), .rd1(rd1), .rd2(rd2)
   );

   // Forward ALU or link result sitting in writeback
   assign fwdA = wRegWrite && (wRd != 5'd0) && (wRd == xRs1);
   assign fwdB = wRegWrite && (wRd != 5'd0) && (wRd == xRs2);
   assign wFwdVal = (wWbSel == WB_LINK) ? wLink : wAluOut;

   assign xPcWord = {{(32 - `PC_BITS){1'b0}}, xPc};
   assign opA = xUsePc ? xPcWord : (fwdA ? wFwdVal : rd1);
   assign xRs2Val = fwdB ? wFwdVal : rd2;
   assign opB = xAluSrcImm ? xImm : xRs2Val;

   aluUnit alu_i (
      .a(opA), .b(opB), .op(xAluOp), .funct3(xF3), .result(aluResult),
      .branchTaken(branchTaken)
   );

   // Load data is only there in writeback, so a dependent op waits one cycle
   assign loadUse = wRegWrite && (wWbSel == WB_LOAD) && (wRd != 5'd0)
                    && ((wRd == xRs1) || (wRd == xRs2));

   assign branchTarget = xPcWord + xImm;
   assign targetPc = xIsJalr ? {aluResult[`PC_BITS-1:1], 1'b0}
                             : branchTarget[`PC_BITS-1:0];
   assign redirect = ~loadUse & (xIsJal | xIsJalr | (xIsBranch & branchTaken));
   assign xLink = xPcWord + 32'd4;

   // Memory ports
   // During a load-use bubble the execute instruction is fetched again
   assign icacheAddr = {{(32 - `PC_BITS){1'b0}}, loadUse ? xPc : pc};
   assign icacheRe = ~stall;
   assign storeEn = xIsStore & ~stall & ~loadUse;
   assign dcacheRe = xIsLoad & ~stall & ~loadUse;
   assign dcacheAddr = aluResult;

   loadStoreAlign lsAlign_i (
      .storeF3(xF3), .loadF3(wF3), .storeEn(storeEn), .storeAddrLow(aluResult[1:0]),
      .loadAddrLow(wAluOut[1:0]), .storeData(xRs2Val), .byteEnables(dcacheWe),
      .shiftedData(dcacheDin), .loadWord(dcacheDout), .loadResult(loadResult)
   );

   always_comb
   begin
      case (wWbSel)
         WB_LOAD: rdVal = loadResult;
         WB_LINK: rdVal = wLink;
         default: rdVal = wAluOut;
      endcase
   end

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= `RESET_PC;
         xNoop <= 1'b1;
         wRegWrite <= 1'b0;
         wWbSel <= WB_ALU;
      end
      else if (!stall)
      begin
         if (loadUse)
         begin
            // Hold PC and execute, bubble into writeback
            wRegWrite <= 1'b0;
            wWbSel <= WB_ALU;
         end
         else
         begin
            pc <= redirect ? targetPc : pc + `PC_BITS'd4;
            xNoop <= redirect;
            wRegWrite <= xRegWrite;
            wWbSel <= xWbSel;
         end
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (!stall && !loadUse)
      begin
         xPc <= pc;
         wRd <= xRd;
         wF3 <= xF3;
         wAluOut <= aluResult;
         wLink <= xLink;
      end
   end

endmodule

/* source/riscv_consts.svh */
// Opcode and funct3 codes, address width, NOP word and reset vector
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Address bits actually decoded by the core
`define PC_BITS 14

`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// Branch conditions
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Load and store sizes, stores use only B, H and W
`define F3_B  3'b000
`define F3_H  3'b001
`define F3_W  3'b010
`define F3_BU 3'b100
`define F3_HU 3'b101

// ALU operations
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// ADDI x0, x0, 0
`define NOP_WORD 32'h0000_0013
`define RESET_PC {`PC_BITS{1'b0}}

`endif

/* source/riscv_pkg.sv */
// Instruction format union, ALU operation and writeback source types
package riscv_pkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sType_t;

   // Branch offset bits are scattered, bit 0 is implied zero
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } bType_t;

   typedef struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uType_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jType_t;

   typedef union packed {
      rType_t r;
      iType_t i;
      sType_t s;
      bType_t b;
      uType_t u;
      jType_t j;
   } instWord_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
   } aluOp_t;

   typedef enum logic [1:0] {
      WB_ALU, WB_LOAD, WB_LINK
   } wbSel_t;

endpackage

/* verification/riscvCore_props.sv */
// Bound assertions on the core memory ports, reset and stall behavior
`timescale 1ns/1ps
module riscvCore_props (
   input logic        clk,
   input logic        rst,
   input logic        stall,
   input logic        icacheRe,
   input logic        dcacheRe,
   input logic [3:0]  dcacheWe,
   input logic [31:0] icacheAddr
);

   // A data access is either a load or a store
   noReadAndWrite: assert property (@(posedge clk) !(dcacheRe && (dcacheWe != 4'b0000)))
      else $error("dcacheRe and dcacheWe high in the same cycle");

   quietWhileStalled: assert property (@(posedge clk)
      stall |-> (!icacheRe && !dcacheRe && (dcacheWe == 4'b0000)))
      else $error("memory enable high while stalled");

   // First reset edge settles the execute stage
   quietInReset: assert property (@(posedge clk)
      (rst && $past(rst)) |-> (!dcacheRe && (dcacheWe == 4'b0000)))
      else $error("data enable high during reset");

   fetchHeld: assert property (@(posedge clk) disable iff (rst)
      stall |=> $stable(icacheAddr))
      else $error("icacheAddr moved while stalled");

endmodule

bind riscvCore riscvCore_props props_i (.*);

/* verification/riscvCore_tb.sv */
// Testbench for riscvCore with memories, test table, program builder, checks and timeout
`timescale 1ns/1ps
`include "riscv_consts.svh"
module riscvCore_tb;

   // Kind codes 0..9 are register ALU ops and 10..18 immediate ALU ops
   localparam int K_ADD = 0, K_ADDI = 10, K_LUI = 19, K_AUIPC = 20;
   localparam int K_LB = 21, K_LH = 22, K_LW = 23, K_LBU = 24, K_LHU = 25;
   localparam int K_SB = 26, K_SH = 27, K_BEQ = 28, K_JAL = 34, K_JALR = 35;
   localparam int K_FWD = 36, K_LDUSE = 37;
   localparam int PROG_LEN = 10, STALL_MARGIN = 14;
   localparam logic [31:0] RESULT_ADDR = 32'h100, MARKER_ADDR = 32'h104;

   logic clk = 1'b0, rst = 1'b1, stall = 1'b0, icacheRe, dcacheRe;
   logic [31:0] icacheAddr, dcacheAddr, dcacheDin;
   logic [31:0] instruction = `NOP_WORD;
   logic [31:0] dcacheDout = 32'd0;
   logic [3:0] dcacheWe;
   logic [31:0] imem [0:255];
   logic [31:0] dmem [0:255];
   logic [31:0] dmemInit [0:255];
   string names[$];
   int kinds[$];
   logic [31:0] opA[$], opB[$], expected[$];
   string curName;
   int seed = 487, errors = 0, cycles = 0, timeoutLimit = 0, pcIdx, t;
   logic stallOn = 1'b0, resultSeen = 1'b0, markerSeen = 1'b0;
   logic [31:0] resultVal;

   riscvCore dut_i (.*);

   always #50 clk = ~clk;

   always @(posedge clk)
      stall <= stallOn ? (($random(seed) & 3) == 0) : 1'b0;

   // Block RAM style memories with data memory reloaded during reset
   always @(posedge clk)
   begin
      if (icacheRe)
         instruction <= imem[icacheAddr[9:2]];
      if (dcacheRe)
         dcacheDout <= dmem[dcacheAddr[9:2]];
      for (int i = 0; i < 256; i++)
         if (rst)
            dmem[i] <= dmemInit[i];
      for (int b = 0; b < 4; b++)
         if (!rst && dcacheWe[b])
            dmem[dcacheAddr[9:2]][8*b +: 8] <= dcacheDin[8*b +: 8];
   end

   always @(negedge clk)
   begin
      if (stall && (icacheRe || dcacheRe || dcacheWe != 4'b0000))
      begin
         errors++;
         $display("test %s: a memory enable was high while stall was high", curName);
      end
      if (!rst && dcacheWe != 4'b0000 && dcacheAddr == RESULT_ADDR)
      begin
         resultSeen = 1'b1;
         resultVal = dcacheDin;
      end
      if (!rst && dcacheWe != 4'b0000 && dcacheAddr == MARKER_ADDR)
         markerSeen = 1'b1;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (timeoutLimit > 0 && cycles >= timeoutLimit)
      begin
         $display("timeout: the tests did not finish within %0d cycles", timeoutLimit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic compareValue(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      if (exp !== act)
      begin
         errors++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
      else
         $display("pass %s value %h", name, act);
   endtask

   // Instruction encoders
   function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, rs1,
                                        logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, `OP_REG};
   endfunction

   function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, rs1,
                                        logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
   endfunction

   function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, rs1,
                                        logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
   endfunction

   function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
   endfunction

   // ALU index 0..9 in the order ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
   function automatic logic [2:0] aluF3(int j);
      logic [2:0] f3Table [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
      return f3Table[j];
   endfunction

   function automatic int immAlu(int kind);
      int map [9] = '{0, 3, 4, 5, 8, 9, 2, 6, 7};
      return map[kind - K_ADDI];
   endfunction

   function automatic logic [31:0] aluRef(int j, logic [31:0] x, logic [31:0] y);
      case (j)
         0: return x + y;
         1: return x - y;
         2: return x << y[4:0];
         3: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         4: return (x < y) ? 32'd1 : 32'd0;
         5: return x ^ y;
         6: return x >> y[4:0];
         // Negative values shift in ones, built from the logical shift
         7: return x[31] ? ~(~x >> y[4:0]) : (x >> y[4:0]);
         8: return x | y;
         default: return x & y;
      endcase
   endfunction

   function automatic logic [31:0] immOperand(int j, logic [31:0] b);
      if (j == 2 || j == 6 || j == 7)
         return {27'd0, b[4:0]};
      return {{20{b[11]}}, b[11:0]};
   endfunction

   // Byte offset within the data word comes from b[9:8]
   function automatic logic [1:0] lsOffset(int kind, logic [31:0] b);
      if (kind == K_LH || kind == K_LHU || kind == K_SH)
         return {b[9], 1'b0};
      if (kind == K_LW)
         return 2'd0;
      return b[9:8];
   endfunction

   function automatic logic [31:0] refResult(int kind, logic [31:0] a, logic [31:0] b);
      logic [31:0] w;
      logic [1:0] off;
      logic taken;
      off = lsOffset(kind, b);
      w = a >> (8 * off);
      if (kind < K_ADDI)
         return aluRef(kind, a, b);
      if (kind < K_LUI)
         return aluRef(immAlu(kind), a, immOperand(immAlu(kind), b));
      case (kind)
         K_LUI: return a & 32'hffff_f000;
         K_AUIPC: return 32'd16 + (a & 32'hffff_f000);
         K_LB: return {{24{w[7]}}, w[7:0]};
         K_LH: return {{16{w[15]}}, w[15:0]};
         K_LW: return a;
         K_LBU: return {24'd0, w[7:0]};
         K_LHU: return {16'd0, w[15:0]};
         K_JAL: return 32'd20;
         K_JALR: return 32'd24;
         K_FWD: return a + b + a - b;
         K_LDUSE: return a + b;
         default:
         begin
            w = a;
            if (kind == K_SB)
               w[8*off +: 8] = b[7:0];
            else if (kind == K_SH)
               w[8*off +: 16] = b[15:0];
            else
            begin
               case (kind - K_BEQ)
                  0: taken = (a == b);
                  1: taken = (a != b);
                  2: taken = ($signed(a) < $signed(b));
                  3: taken = ($signed(a) >= $signed(b));
                  4: taken = (a < b);
                  default: taken = (a >= b);
               endcase
               w = taken ? 32'd0 : 32'd1;
            end
            return w;
         end
      endcase
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[pcIdx] = word;
      pcIdx++;
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = v + 32'h800;
      emit({hi[31:12], rd, `OP_LUI});
      emit(encI(v[11:0], rd, `F3_ADD, rd, `OP_IMM));
   endtask

   task automatic buildProgram(input int kind, input logic [31:0] a, input logic [31:0] b);
      logic [2:0] brF3 [6] = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
      logic [2:0] ldF3 [5] = '{`F3_B, `F3_H, `F3_W, `F3_BU, `F3_HU};
      logic [11:0] off;
      int j;
      for (int i = 0; i < 256; i++)
      begin
         imem[i] = `NOP_WORD;
         dmemInit[i] = 32'hc0de_0000 | i;
      end
      dmemInit[128] = a;
      off = 12'h200 + {10'd0, lsOffset(kind, b)};
      pcIdx = 0;
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      if (kind < K_ADDI)
         emit(encR({1'b0, kind == 1 || kind == 7, 5'd0}, 2, 1, aluF3(kind), 3));
      else if (kind < K_LUI)
      begin
         j = immAlu(kind);
         emit(encI((j == 2 || j == 6 || j == 7) ? {1'b0, j == 7, 5'd0, b[4:0]} : b[11:0],
                   1, aluF3(j), 3, `OP_IMM));
      end
      else if (kind == K_LUI || kind == K_AUIPC)
         emit({a[31:12], 5'd3, kind == K_LUI ? `OP_LUI : `OP_AUIPC});
      else if (kind <= K_LHU)
         emit(encI(off, 0, ldF3[kind - K_LB], 3, `OP_LOAD));
      else if (kind == K_SB || kind == K_SH)
      begin
         emit(encS(off, 2, 0, kind == K_SB ? `F3_B : `F3_H));
         emit(encI(12'h200, 0, `F3_W, 3, `OP_LOAD));
      end
      else if (kind < K_JAL)
      begin
         // Taken branch skips the ADDI that sets x3 to one
         emit(encI(12'd0, 0, `F3_ADD, 3, `OP_IMM));
         emit(encB(13'd8, 2, 1, brF3[kind - K_BEQ]));
         emit(encI(12'd1, 0, `F3_ADD, 3, `OP_IMM));
      end
      else if (kind == K_JAL)
      begin
         emit(encJ(21'd8, 3));
         emit(encS(MARKER_ADDR[11:0], 0, 0, `F3_W));
      end
      else if (kind == K_JALR)
      begin
         emit(encI(12'd28, 0, `F3_ADD, 4, `OP_IMM));
         emit(encI(12'd0, 4, 3'b000, 3, `OP_JALR));
         emit(encS(MARKER_ADDR[11:0], 0, 0, `F3_W));
      end
      else if (kind == K_FWD)
      begin
         emit(encR(7'h00, 2, 1, `F3_ADD, 3));
         emit(encR(7'h00, 1, 3, `F3_ADD, 3));
         emit(encR(7'h20, 2, 3, `F3_ADD, 3));
      end
      else
      begin
         emit(encI(12'h200, 0, `F3_W, 5, `OP_LOAD));
         emit(encR(7'h00, 2, 5, `F3_ADD, 3));
      end
      emit(encS(RESULT_ADDR[11:0], 3, 0, `F3_W));
   endtask

   task automatic addTest(input string name, input int kind, input logic [31:0] a,
                          input logic [31:0] b);
      names.push_back(name);
      kinds.push_back(kind);
      opA.push_back(a);
      opB.push_back(b);
      expected.push_back(refResult(kind, a, b));
   endtask

   initial
   begin
      addTest("add", K_ADD, 32'h1234_5678, 32'h0fed_cba9);
      addTest("sub", K_ADD + 1, 32'd5, 32'd9);
      addTest("sll", K_ADD + 2, 32'h8000_00f1, 32'd35);
      addTest("slt", K_ADD + 3, 32'hffff_fff0, 32'd5);
      addTest("sltu", K_ADD + 4, 32'hffff_fff0, 32'd5);
      addTest("xor", K_ADD + 5, 32'hf0f0_1234, 32'h0ff0_4321);
      addTest("srl", K_ADD + 6, 32'h8000_1234, 32'd4);
      addTest("sra", K_ADD + 7, 32'h8000_1234, 32'd4);
      addTest("or", K_ADD + 8, 32'ha000_0005, 32'h0f00_0035);
      addTest("and", K_ADD + 9, 32'hff00_ff0f, 32'h0ff0_f0ff);
      addTest("addi", K_ADDI, 32'd100, 32'h0000_0ff0);
      addTest("slti", K_ADDI + 1, 32'hffff_ffec, 32'h0000_0010);
      addTest("sltiu", K_ADDI + 2, 32'd5, 32'h0000_0fff);
      addTest("xori", K_ADDI + 3, 32'h1234_5678, 32'h0000_0f0f);
      addTest("ori", K_ADDI + 4, 32'h1234_5678, 32'h0000_0876);
      addTest("andi", K_ADDI + 5, 32'h1234_5678, 32'h0000_0ff0);
      addTest("slli", K_ADDI + 6, 32'h0000_0123, 32'd7);
      addTest("srli", K_ADDI + 7, 32'hf000_0000, 32'd8);
      addTest("srai", K_ADDI + 8, 32'hf000_0000, 32'd8);
      addTest("lui", K_LUI, 32'hdead_beef, 32'd0);
      addTest("auipc", K_AUIPC, 32'h0001_2345, 32'd0);
      addTest("lb", K_LB, 32'h80ff_7f81, 32'h0000_0300);
      addTest("lh", K_LH, 32'h80ff_7f81, 32'h0000_0200);
      addTest("lw", K_LW, 32'h80ff_7f81, 32'd0);
      addTest("lbu", K_LBU, 32'h80ff_7f81, 32'h0000_0300);
      addTest("lhu", K_LHU, 32'h80ff_7f81, 32'h0000_0200);
      addTest("sb", K_SB, 32'h1122_3344, 32'h0000_02aa);
      addTest("sh", K_SH, 32'h1122_3344, 32'h0000_02bb);
      addTest("beq taken", K_BEQ, 32'd7, 32'd7);
      addTest("beq untaken", K_BEQ, 32'd7, 32'd8);
      addTest("bne taken", K_BEQ + 1, 32'd7, 32'd8);
      addTest("bne untaken", K_BEQ + 1, 32'd7, 32'd7);
      addTest("blt taken", K_BEQ + 2, 32'hffff_ffff, 32'd1);
      addTest("blt untaken", K_BEQ + 2, 32'd1, 32'hffff_ffff);
      addTest("bge taken", K_BEQ + 3, 32'd1, 32'hffff_ffff);
      addTest("bge untaken", K_BEQ + 3, 32'hffff_ffff, 32'd1);
      addTest("bltu taken", K_BEQ + 4, 32'd1, 32'hffff_ffff);
      addTest("bltu untaken", K_BEQ + 4, 32'hffff_ffff, 32'd1);
      addTest("bgeu taken", K_BEQ + 5, 32'hffff_ffff, 32'd1);
      addTest("bgeu untaken", K_BEQ + 5, 32'd1, 32'hffff_ffff);
      addTest("jal", K_JAL, 32'd0, 32'd0);
      addTest("jalr", K_JALR, 32'd0, 32'd0);
      addTest("forward chain", K_FWD, 32'h0000_1234, 32'h0000_0777);
      addTest("load use", K_LDUSE, 32'h0100_0001, 32'h0000_0022);
      timeoutLimit = names.size() * (PROG_LEN + STALL_MARGIN) * 2;

      for (t = 0; t < names.size(); t++)
      begin
         curName = names[t];
         @(posedge clk);
         rst <= 1'b1;
         @(posedge clk);
         buildProgram(kinds[t], opA[t], opB[t]);
         @(posedge clk);
         rst <= 1'b0;
         @(negedge clk);
         if (t == 0)
         begin
            compareValue("reset icacheAddr", {{(32 - `PC_BITS){1'b0}}, `RESET_PC},
                         icacheAddr);
            compareValue("reset dcacheWe", 32'd0, {28'd0, dcacheWe});
            compareValue("reset dcacheRe", 32'd0, {31'd0, dcacheRe});
         end
         resultSeen = 1'b0;
         markerSeen = 1'b0;
         stallOn = 1'b1;
         while (!resultSeen)
            @(posedge clk);
         stallOn = 1'b0;
         compareValue(names[t], expected[t], resultVal);
         if (markerSeen)
         begin
            errors++;
            $display("test %s: the instruction after the jump was executed", curName);
         end
      end

      $display("tests %0d failed checks %0d", names.size(), errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
